// ==== design/core_pkg.sv ====
package core_pkg;

    // data path widths
    localparam int xlen       = 32;
    localparam int strb_w     = xlen / 8;
    localparam int reg_addr_w = 5;
    localparam int csr_addr_w = 12;

    // data memory geometry, in words
    localparam int mem_words = 256;
    localparam int mem_idx_w = $clog2(mem_words);

    // memory op codes
    localparam int mem_op_w = 3;
    localparam logic [mem_op_w-1:0] mem_none = 3'd0;
    localparam logic [mem_op_w-1:0] mem_lw   = 3'd1;
    localparam logic [mem_op_w-1:0] mem_lbu  = 3'd2;
    localparam logic [mem_op_w-1:0] mem_sw   = 3'd3;
    localparam logic [mem_op_w-1:0] mem_sb   = 3'd4;

    // csr op codes, same encoding as csr_type of the execute stage
    localparam int csr_op_w = 3;
    localparam logic [csr_op_w-1:0] csr_none = 3'd0;
    localparam logic [csr_op_w-1:0] csr_rw   = 3'd1;
    localparam logic [csr_op_w-1:0] csr_rs   = 3'd2;
    localparam logic [csr_op_w-1:0] csr_rc   = 3'd3;

    // implemented machine csrs
    localparam logic [csr_addr_w-1:0] csr_mstatus  = 12'h300;
    localparam logic [csr_addr_w-1:0] csr_mtvec    = 12'h305;
    localparam logic [csr_addr_w-1:0] csr_mepc     = 12'h341;
    localparam logic [csr_addr_w-1:0] csr_mcause   = 12'h342;
    localparam logic [csr_addr_w-1:0] csr_minstret = 12'hb02;

endpackage

// ==== design/data_mem.sv ====
`timescale 1ns/1ps

module data_mem
    import core_pkg::*;
(
    input  logic              clock,
    input  logic [xlen-1:0]   mem_addr_i,
    input  logic [xlen-1:0]   mem_wdata_i,
    input  logic [strb_w-1:0] mem_wstrb_i,
    input  logic              mem_ren_i,
    output logic [xlen-1:0]   mem_rdata_o
);

    logic [xlen-1:0]      mem [mem_words];
    logic [mem_idx_w-1:0] word_idx;

    // byte address in, word index out
    assign word_idx = mem_addr_i[mem_idx_w+1:2];

    // byte lane writes
    always_ff @(posedge clock) begin
        for (int b = 0; b < strb_w; b++) begin
            if (mem_wstrb_i[b]) begin
                mem[word_idx][b*8 +: 8] <= mem_wdata_i[b*8 +: 8];
            end
        end
    end

    // registered read, holds last word when idle
    always_ff @(posedge clock) begin
        if (mem_ren_i) begin
            mem_rdata_o <= mem[word_idx];
        end
    end

endmodule

// ==== design/lsu.sv ====
`timescale 1ns/1ps

module lsu
    import core_pkg::*;
(
    input  logic                  clock,
    input  logic                  rst_i,
    input  logic                  ex_valid_i,
    output logic                  lsu_ready_o,
    input  logic                  wd_i,
    input  logic [reg_addr_w-1:0] wreg_i,
    input  logic [xlen-1:0]       alu_result_i,
    input  logic [mem_op_w-1:0]   mem_op_i,
    input  logic [xlen-1:0]       store_data_i,
    input  logic [csr_op_w-1:0]   csr_type_i,
    input  logic [csr_addr_w-1:0] csr_waddr_i,
    input  logic [xlen-1:0]       csr_wdata_i,
    input  logic                  ebreak_i,
    input  logic                  halt_i,
    output logic [xlen-1:0]       mem_addr_o,
    output logic [xlen-1:0]       mem_wdata_o,
    output logic [strb_w-1:0]     mem_wstrb_o,
    output logic                  mem_ren_o,
    input  logic [xlen-1:0]       mem_rdata_i,
    output logic                  lsu_valid_o,
    output logic                  wd_o,
    output logic [reg_addr_w-1:0] wreg_o,
    output logic [xlen-1:0]       reg_wdata_o,
    output logic [csr_op_w-1:0]   csr_type_o,
    output logic [csr_addr_w-1:0] csr_waddr_o,
    output logic [xlen-1:0]       csr_wdata_o,
    output logic                  ebreak_o
);

    // accept stage
    logic                  a_valid;
    logic                  a_wd;
    logic [reg_addr_w-1:0] a_wreg;
    logic [xlen-1:0]       a_result;
    logic [mem_op_w-1:0]   a_mem_op;
    logic [xlen-1:0]       a_store_data;
    logic [csr_op_w-1:0]   a_csr_type;
    logic [csr_addr_w-1:0] a_csr_waddr;
    logic [xlen-1:0]       a_csr_wdata;
    logic                  a_ebreak;
    logic                  ld_pend;

    logic a_load;
    logic a_store;
    logic a_fire;
    logic accept;

    // output stage extras for load data select
    logic       out_load;
    logic       out_lbu;
    logic [1:0] out_lane;
    logic [xlen-1:0] out_result;
    logic [7:0] ld_byte;

    assign a_load  = a_valid && (a_mem_op == mem_lw || a_mem_op == mem_lbu);
    assign a_store = a_valid && (a_mem_op == mem_sw || a_mem_op == mem_sb);

    // a load leaves the accept stage only after its pending cycle
    assign a_fire = a_valid && (!a_load || ld_pend);

    // hold execute while a load sits in its first cycle
    assign lsu_ready_o = !halt_i && !(a_load && !ld_pend);
    assign accept      = ex_valid_i && lsu_ready_o;

    always_ff @(posedge clock) begin
        if (rst_i) begin
            a_valid     <= 1'b0;
            ld_pend     <= 1'b0;
            lsu_valid_o <= 1'b0;
        end else begin
            if (accept) begin
                a_valid <= 1'b1;
            end else if (a_fire) begin
                a_valid <= 1'b0;
            end
            ld_pend     <= a_load && !ld_pend;
            lsu_valid_o <= a_fire;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            a_wd         <= wd_i;
            a_wreg       <= wreg_i;
            a_result     <= alu_result_i;
            a_mem_op     <= mem_op_i;
            a_store_data <= store_data_i;
            a_csr_type   <= csr_type_i;
            a_csr_waddr  <= csr_waddr_i;
            a_csr_wdata  <= csr_wdata_i;
            a_ebreak     <= ebreak_i;
        end
        if (a_fire) begin
            wd_o        <= a_wd;
            wreg_o      <= a_wreg;
            out_result  <= a_result;
            csr_type_o  <= a_csr_type;
            csr_waddr_o <= a_csr_waddr;
            csr_wdata_o <= a_csr_wdata;
            ebreak_o    <= a_ebreak;
            out_load    <= a_load;
            out_lbu     <= (a_mem_op == mem_lbu);
            out_lane    <= a_result[1:0];
        end
    end

    // memory side, stores go out straight from the accept stage
    assign mem_addr_o  = a_result;
    assign mem_ren_o   = ld_pend;
    assign mem_wdata_o = (a_mem_op == mem_sb) ? {strb_w{a_store_data[7:0]}} : a_store_data;

    always_comb begin
        mem_wstrb_o = '0;
        if (a_store) begin
            if (a_mem_op == mem_sb) begin
                mem_wstrb_o = strb_w'(1) << a_result[1:0];
            end else begin
                mem_wstrb_o = '1;
            end
        end
    end

    // load data arrives in the commit cycle
    assign ld_byte     = mem_rdata_i[{out_lane, 3'b000} +: 8];
    assign reg_wdata_o = !out_load ? out_result :
                         out_lbu   ? {{(xlen-8){1'b0}}, ld_byte} : mem_rdata_i;

endmodule

// ==== design/wbu.sv ====
`timescale 1ns/1ps

module wbu
    import core_pkg::*;
(
    input  logic                  clock,
    input  logic                  rst_i,
    input  logic                  lsu_valid_i,
    input  logic                  wd_i,
    input  logic [reg_addr_w-1:0] wreg_i,
    input  logic [xlen-1:0]       reg_wdata_i,
    input  logic [csr_op_w-1:0]   csr_type_i,
    input  logic [csr_addr_w-1:0] csr_waddr_i,
    input  logic [xlen-1:0]       csr_wdata_i,
    input  logic                  ebreak_i,
    output logic                  rf_we_o,
    output logic [reg_addr_w-1:0] rf_waddr_o,
    output logic [xlen-1:0]       rf_wdata_o,
    output logic [csr_op_w-1:0]   csr_type_o,
    output logic [csr_addr_w-1:0] csr_waddr_o,
    output logic [xlen-1:0]       csr_wdata_o,
    output logic                  retire_o,
    output logic                  halt_o
);

    // commit fields only pass while valid
    always_comb begin
        if (lsu_valid_i) begin
            rf_we_o     = wd_i;
            rf_waddr_o  = wreg_i;
            rf_wdata_o  = reg_wdata_i;
            csr_type_o  = csr_type_i;
            csr_waddr_o = csr_waddr_i;
            csr_wdata_o = csr_wdata_i;
        end else begin
            rf_we_o     = 1'b0;
            rf_waddr_o  = '0;
            rf_wdata_o  = '0;
            csr_type_o  = csr_none;
            csr_waddr_o = '0;
            csr_wdata_o = '0;
        end
    end

    assign retire_o = lsu_valid_i;

    // sticky until reset
    always_ff @(posedge clock) begin
        if (rst_i) begin
            halt_o <= 1'b0;
        end else if (lsu_valid_i && ebreak_i) begin
            halt_o <= 1'b1;
        end
    end

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ps

module reg_file
    import core_pkg::*;
(
    input  logic                  clock,
    input  logic                  rst_i,
    input  logic                  we_i,
    input  logic [reg_addr_w-1:0] waddr_i,
    input  logic [xlen-1:0]       wdata_i,
    input  logic [reg_addr_w-1:0] raddr1_i,
    input  logic [reg_addr_w-1:0] raddr2_i,
    output logic [xlen-1:0]       rdata1_o,
    output logic [xlen-1:0]       rdata2_o
);

    localparam int num_regs = 2 ** reg_addr_w;

    logic [xlen-1:0] regs [num_regs];

    always_ff @(posedge clock) begin
        if (rst_i) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            // x0 never written, so it reads zero
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = regs[raddr1_i];
    assign rdata2_o = regs[raddr2_i];

endmodule

// ==== design/csr_file.sv ====
`timescale 1ns/1ps

module csr_file
    import core_pkg::*;
(
    input  logic                  clock,
    input  logic                  rst_i,
    input  logic [csr_op_w-1:0]   csr_type_i,
    input  logic [csr_addr_w-1:0] csr_waddr_i,
    input  logic [xlen-1:0]       csr_wdata_i,
    input  logic                  retire_i,
    input  logic [csr_addr_w-1:0] raddr_i,
    output logic [xlen-1:0]       rdata_o
);

    logic [xlen-1:0] mstatus;
    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mepc;
    logic [xlen-1:0] mcause;
    logic [xlen-1:0] minstret;

    logic            csr_we;
    logic [xlen-1:0] cur_val;
    logic [xlen-1:0] new_val;

    // unknown addresses read zero
    function automatic logic [xlen-1:0] read_csr(input logic [csr_addr_w-1:0] addr);
        logic [xlen-1:0] val;
        case (addr)
            csr_mstatus:  val = mstatus;
            csr_mtvec:    val = mtvec;
            csr_mepc:     val = mepc;
            csr_mcause:   val = mcause;
            csr_minstret: val = minstret;
            default:      val = '0;
        endcase
        return val;
    endfunction

    assign rdata_o = read_csr(raddr_i);
    assign cur_val = read_csr(csr_waddr_i);
    assign csr_we  = (csr_type_i != csr_none);

    always_comb begin
        case (csr_type_i)
            csr_rs:  new_val = cur_val | csr_wdata_i;
            csr_rc:  new_val = cur_val & ~csr_wdata_i;
            default: new_val = csr_wdata_i;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst_i) begin
            mstatus  <= '0;
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
            minstret <= '0;
        end else begin
            if (csr_we) begin
                case (csr_waddr_i)
                    csr_mstatus: mstatus <= new_val;
                    csr_mtvec:   mtvec   <= new_val;
                    csr_mepc:    mepc    <= new_val;
                    csr_mcause:  mcause  <= new_val;
                    default:     ;
                endcase
            end
            // explicit write wins over the retire count
            if (csr_we && csr_waddr_i == csr_minstret) begin
                minstret <= new_val;
            end else if (retire_i) begin
                minstret <= minstret + 1'b1;
            end
        end
    end

endmodule

// ==== design/backend.sv ====
`timescale 1ns/1ps

module backend
    import core_pkg::*;
(
    input  logic                  clock,
    input  logic                  rst_i,
    input  logic                  ex_valid_i,
    output logic                  lsu_ready_o,
    input  logic                  wd_i,
    input  logic [reg_addr_w-1:0] wreg_i,
    input  logic [xlen-1:0]       alu_result_i,
    input  logic [mem_op_w-1:0]   mem_op_i,
    input  logic [xlen-1:0]       store_data_i,
    input  logic [csr_op_w-1:0]   csr_type_i,
    input  logic [csr_addr_w-1:0] csr_waddr_i,
    input  logic [xlen-1:0]       csr_wdata_i,
    input  logic                  ebreak_i,
    input  logic [reg_addr_w-1:0] rs1_i,
    input  logic [reg_addr_w-1:0] rs2_i,
    output logic [xlen-1:0]       rs1_data_o,
    output logic [xlen-1:0]       rs2_data_o,
    input  logic [csr_addr_w-1:0] csr_raddr_i,
    output logic [xlen-1:0]       csr_rdata_o,
    output logic                  halt_o
);

    // lsu to memory
    logic [xlen-1:0]   mem_addr;
    logic [xlen-1:0]   mem_wdata;
    logic [strb_w-1:0] mem_wstrb;
    logic              mem_ren;
    logic [xlen-1:0]   mem_rdata;

    // lsu to wbu
    logic                  lsu_valid;
    logic                  wd;
    logic [reg_addr_w-1:0] wreg;
    logic [xlen-1:0]       reg_wdata;
    logic [csr_op_w-1:0]   csr_type;
    logic [csr_addr_w-1:0] csr_waddr;
    logic [xlen-1:0]       csr_wdata;
    logic                  ebreak;

    // wbu to state files
    logic                  rf_we;
    logic [reg_addr_w-1:0] rf_waddr;
    logic [xlen-1:0]       rf_wdata;
    logic [csr_op_w-1:0]   wb_csr_type;
    logic [csr_addr_w-1:0] wb_csr_waddr;
    logic [xlen-1:0]       wb_csr_wdata;
    logic                  retire;

    lsu lsu_i (
        .clock(clock), .rst_i(rst_i),
        .ex_valid_i(ex_valid_i), .lsu_ready_o(lsu_ready_o),
        .wd_i(wd_i), .wreg_i(wreg_i), .alu_result_i(alu_result_i),
        .mem_op_i(mem_op_i), .store_data_i(store_data_i),
        .csr_type_i(csr_type_i), .csr_waddr_i(csr_waddr_i), .csr_wdata_i(csr_wdata_i),
        .ebreak_i(ebreak_i), .halt_i(halt_o),
        .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata), .mem_wstrb_o(mem_wstrb),
        .mem_ren_o(mem_ren), .mem_rdata_i(mem_rdata),
        .lsu_valid_o(lsu_valid), .wd_o(wd), .wreg_o(wreg), .reg_wdata_o(reg_wdata),
        .csr_type_o(csr_type), .csr_waddr_o(csr_waddr), .csr_wdata_o(csr_wdata),
        .ebreak_o(ebreak)
    );

    data_mem data_mem_i (
        .clock(clock), .mem_addr_i(mem_addr), .mem_wdata_i(mem_wdata),
        .mem_wstrb_i(mem_wstrb), .mem_ren_i(mem_ren), .mem_rdata_o(mem_rdata)
    );

    wbu wbu_i (
        .clock(clock), .rst_i(rst_i), .lsu_valid_i(lsu_valid),
        .wd_i(wd), .wreg_i(wreg), .reg_wdata_i(reg_wdata),
        .csr_type_i(csr_type), .csr_waddr_i(csr_waddr), .csr_wdata_i(csr_wdata),
        .ebreak_i(ebreak),
        .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
        .csr_type_o(wb_csr_type), .csr_waddr_o(wb_csr_waddr), .csr_wdata_o(wb_csr_wdata),
        .retire_o(retire), .halt_o(halt_o)
    );

    reg_file reg_file_i (
        .clock(clock), .rst_i(rst_i),
        .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata),
        .raddr1_i(rs1_i), .raddr2_i(rs2_i),
        .rdata1_o(rs1_data_o), .rdata2_o(rs2_data_o)
    );

    csr_file csr_file_i (
        .clock(clock), .rst_i(rst_i),
        .csr_type_i(wb_csr_type), .csr_waddr_i(wb_csr_waddr), .csr_wdata_i(wb_csr_wdata),
        .retire_i(retire), .raddr_i(csr_raddr_i), .rdata_o(csr_rdata_o)
    );

endmodule

// ==== tests/backend_asserts.sv ====
`timescale 1ns/1ps

module backend_asserts
    import core_pkg::*;
(
    input logic                  clock,
    input logic                  rst_i,
    input logic                  ex_valid_i,
    input logic                  ready_i,
    input logic                  wd_i,
    input logic [reg_addr_w-1:0] wreg_i,
    input logic [xlen-1:0]       alu_result_i,
    input logic [mem_op_w-1:0]   mem_op_i,
    input logic [xlen-1:0]       store_data_i,
    input logic                  ebreak_i,
    input logic [reg_addr_w-1:0] rs2_i,
    input logic [xlen-1:0]       rs2_data_i,
    input logic                  halt_i
);

    localparam int num_regs = 2 ** reg_addr_w;

    logic [xlen-1:0] shadow [num_regs];
    logic [xlen-1:0] smem [mem_words];

    // commit delay line, slot 0 lands on the next edge
    logic                  slot_we  [3];
    logic [reg_addr_w-1:0] slot_rd  [3];
    logic [xlen-1:0]       slot_val [3];

    logic                 accept;
    logic                 is_load;
    logic [mem_idx_w-1:0] idx;
    logic [xlen-1:0]      ld_val;
    logic [xlen-1:0]      shadow_rd;
    int unsigned          fail_count = 0;

    assign accept    = ex_valid_i && ready_i;
    assign is_load   = (mem_op_i == mem_lw) || (mem_op_i == mem_lbu);
    assign idx       = alu_result_i[mem_idx_w+1:2];
    assign shadow_rd = shadow[rs2_i];
    assign ld_val    = (mem_op_i == mem_lbu) ?
                       {{(xlen-8){1'b0}}, smem[idx][{alu_result_i[1:0], 3'b000} +: 8]} :
                       smem[idx];

    // stores land in the shadow memory in program order
    always_ff @(posedge clock) begin
        if (!rst_i && accept && mem_op_i == mem_sw) begin
            smem[idx] <= store_data_i;
        end
        if (!rst_i && accept && mem_op_i == mem_sb) begin
            smem[idx][{alu_result_i[1:0], 3'b000} +: 8] <= store_data_i[7:0];
        end
    end

    always_ff @(posedge clock) begin
        if (rst_i) begin
            for (int s = 0; s < 3; s++) begin
                slot_we[s] <= 1'b0;
            end
            for (int r = 0; r < num_regs; r++) begin
                shadow[r] <= '0;
            end
        end else begin
            if (slot_we[0] && slot_rd[0] != '0) begin
                shadow[slot_rd[0]] <= slot_val[0];
            end
            for (int s = 0; s < 2; s++) begin
                slot_we[s]  <= slot_we[s+1];
                slot_rd[s]  <= slot_rd[s+1];
                slot_val[s] <= slot_val[s+1];
            end
            slot_we[2] <= 1'b0;
            // loads commit one edge later than everything else
            if (accept && is_load) begin
                slot_we[2]  <= wd_i;
                slot_rd[2]  <= wreg_i;
                slot_val[2] <= ld_val;
            end else if (accept) begin
                slot_we[1]  <= wd_i;
                slot_rd[1]  <= wreg_i;
                slot_val[1] <= alu_result_i;
            end
        end
    end

    rf_match: assert property (@(posedge clock) disable iff (rst_i)
        rs2_data_i == shadow_rd)
        else begin
            fail_count++;
            $error("register read on rs2 differs from the shadow register file");
        end

    ld_hold: assert property (@(posedge clock) disable iff (rst_i)
        $past(accept && is_load) |-> !ready_i)
        else begin
            fail_count++;
            $error("ready stayed high in the cycle after a load was accepted");
        end

    ld_release: assert property (@(posedge clock) disable iff (rst_i)
        $past(accept && is_load, 2) |-> ready_i)
        else begin
            fail_count++;
            $error("ready stayed low for more than one cycle after a load");
        end

    no_stall: assert property (@(posedge clock) disable iff (rst_i)
        $past(accept && !is_load) |-> ready_i)
        else begin
            fail_count++;
            $error("ready dropped after a non-load item");
        end

    halt_rise: assert property (@(posedge clock) disable iff (rst_i)
        $past(accept && ebreak_i && !is_load, 3) |-> halt_i)
        else begin
            fail_count++;
            $error("halt did not rise on the edge after ebreak committed");
        end

    halt_sticky: assert property (@(posedge clock) disable iff (rst_i)
        $past(halt_i) |-> halt_i)
        else begin
            fail_count++;
            $error("halt dropped without a reset");
        end

    halt_blocks: assert property (@(posedge clock) disable iff (rst_i)
        halt_i |-> !ready_i)
        else begin
            fail_count++;
            $error("ready is high while halted");
        end

endmodule

// ==== tests/backend_tb.sv ====
`timescale 1ns/1ps

module backend_tb;
    import core_pkg::*;

    localparam int clk_period   = 20;
    localparam int reset_cycles = 16;
    localparam int n_rand       = 24;
    // 3 directed alu, 7 csr ops, 6 per random round, 1 ebreak
    localparam int total_items  = 11 + 6 * n_rand;
    localparam logic [csr_addr_w-1:0] csr_unimpl = 12'h7c0;

    logic                  clock;
    logic                  rst_i;
    logic                  ex_valid_i;
    logic                  lsu_ready_o;
    logic                  wd_i;
    logic [reg_addr_w-1:0] wreg_i;
    logic [xlen-1:0]       alu_result_i;
    logic [mem_op_w-1:0]   mem_op_i;
    logic [xlen-1:0]       store_data_i;
    logic [csr_op_w-1:0]   csr_type_i;
    logic [csr_addr_w-1:0] csr_waddr_i;
    logic [xlen-1:0]       csr_wdata_i;
    logic                  ebreak_i;
    logic [reg_addr_w-1:0] rs1_i;
    logic [reg_addr_w-1:0] rs2_i;
    logic [xlen-1:0]       rs1_data_o;
    logic [xlen-1:0]       rs2_data_o;
    logic [csr_addr_w-1:0] csr_raddr_i;
    logic [xlen-1:0]       csr_rdata_o;
    logic                  halt_o;

    // reference state
    logic [xlen-1:0] model_regs [32];
    logic [xlen-1:0] model_mtvec;
    logic [xlen-1:0] model_mepc;
    int              issued;
    integer          seed;

    backend dut_i (.*);

    bind backend backend_asserts asserts_i (
        .clock(clock), .rst_i(rst_i), .ex_valid_i(ex_valid_i), .ready_i(lsu_ready_o),
        .wd_i(wd_i), .wreg_i(wreg_i), .alu_result_i(alu_result_i), .mem_op_i(mem_op_i),
        .store_data_i(store_data_i), .ebreak_i(ebreak_i), .rs2_i(rs2_i),
        .rs2_data_i(rs2_data_o), .halt_i(halt_o)
    );

    initial begin
        clock = 1'b0;
        forever #(clk_period / 2) clock = ~clock;
    end

    initial begin
        #((reset_cycles + 40 * total_items) * clk_period);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired before the test sequence finished");
    end

    // concurrent assertion failures end the run here
    always @(posedge clock) begin
        if (dut_i.asserts_i.fail_count != 0) begin
            $display("ERRORS FOUND");
            $fatal(1, "an assertion in backend_asserts failed");
        end
    end

    function automatic logic [xlen-1:0] csr_next(input logic [csr_op_w-1:0] op,
                                                 input logic [xlen-1:0] old,
                                                 input logic [xlen-1:0] val);
        case (op)
            csr_rs:  return old | val;
            csr_rc:  return old & ~val;
            default: return val;
        endcase
    endfunction

    task automatic check(input string name, input logic [xlen-1:0] got,
                         input logic [xlen-1:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "value check failed");
        end
    endtask

    // hold one item until the lsu takes it, then update the model
    task automatic send(input logic wd, input logic [reg_addr_w-1:0] rd,
                        input logic [xlen-1:0] res, input logic [mem_op_w-1:0] op,
                        input logic [xlen-1:0] sdata, input logic [csr_op_w-1:0] ctype,
                        input logic [csr_addr_w-1:0] caddr, input logic [xlen-1:0] cdata,
                        input logic eb, input logic [xlen-1:0] exp);
        logic taken;
        ex_valid_i   <= 1'b1;
        wd_i         <= wd;
        wreg_i       <= rd;
        alu_result_i <= res;
        mem_op_i     <= op;
        store_data_i <= sdata;
        csr_type_i   <= ctype;
        csr_waddr_i  <= caddr;
        csr_wdata_i  <= cdata;
        ebreak_i     <= eb;
        rs2_i        <= rd;
        // ready seen mid cycle decides whether the coming edge accepts
        do begin
            @(negedge clock);
            taken = lsu_ready_o;
            @(posedge clock);
        end while (!taken);
        issued++;
        if (wd && rd != '0) begin
            model_regs[rd] = exp;
        end
        if (ctype != csr_none && caddr == csr_mtvec) begin
            model_mtvec = csr_next(ctype, model_mtvec, cdata);
        end
        if (ctype != csr_none && caddr == csr_mepc) begin
            model_mepc = csr_next(ctype, model_mepc, cdata);
        end
    endtask

    task automatic idle(input int cycles);
        ex_valid_i <= 1'b0;
        repeat (cycles) @(posedge clock);
    endtask

    task automatic alu(input logic wd, input logic [reg_addr_w-1:0] rd,
                       input logic [xlen-1:0] val);
        send(wd, rd, val, mem_none, '0, csr_none, '0, '0, 1'b0, val);
    endtask

    task automatic store(input logic [mem_op_w-1:0] op, input logic [xlen-1:0] addr,
                         input logic [xlen-1:0] data);
        send(1'b0, '0, addr, op, data, csr_none, '0, '0, 1'b0, '0);
    endtask

    task automatic load(input logic [mem_op_w-1:0] op, input logic [reg_addr_w-1:0] rd,
                        input logic [xlen-1:0] addr, input logic [xlen-1:0] exp);
        send(1'b1, rd, addr, op, '0, csr_none, '0, '0, 1'b0, exp);
    endtask

    task automatic check_csr(input logic [csr_addr_w-1:0] addr, input logic [xlen-1:0] exp);
        csr_raddr_i <= addr;
        @(posedge clock);
        check($sformatf("csr_rdata_o[%h]", addr), csr_rdata_o, exp);
    endtask

    // commit lands within three edges, four leaves margin
    task automatic csr_step(input logic [csr_op_w-1:0] op, input logic [csr_addr_w-1:0] addr,
                            input logic [xlen-1:0] val);
        logic [xlen-1:0] exp;
        send(1'b0, '0, '0, mem_none, '0, op, addr, val, 1'b0, '0);
        idle(4);
        if (addr == csr_mtvec) begin
            exp = model_mtvec;
        end else if (addr == csr_mepc) begin
            exp = model_mepc;
        end else begin
            exp = '0;
        end
        check_csr(addr, exp);
    endtask

    initial begin
        logic [xlen-1:0]       addr;
        logic [xlen-1:0]       data;
        logic [xlen-1:0]       merged;
        logic [7:0]            bval;
        logic [1:0]            lane;
        logic [reg_addr_w-1:0] rd;
        seed         = 15;
        issued       = 0;
        rst_i        = 1'b1;
        ex_valid_i   = 1'b0;
        wd_i         = 1'b0;
        wreg_i       = '0;
        alu_result_i = '0;
        mem_op_i     = mem_none;
        store_data_i = '0;
        csr_type_i   = csr_none;
        csr_waddr_i  = '0;
        csr_wdata_i  = '0;
        ebreak_i     = 1'b0;
        rs1_i        = '0;
        rs2_i        = '0;
        csr_raddr_i  = '0;
        model_mtvec  = '0;
        model_mepc   = '0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (reset_cycles) @(posedge clock);
        rst_i <= 1'b0;

        alu(1'b1, 5'd1, 32'hdead_beef);
        alu(1'b1, 5'd0, 32'hffff_ffff);
        alu(1'b0, 5'd2, 32'h0000_0042);

        csr_step(csr_rw, csr_mtvec, 32'h8000_0100);
        csr_step(csr_rs, csr_mtvec, 32'h0000_00ff);
        csr_step(csr_rc, csr_mtvec, 32'h0000_000f);
        csr_step(csr_rw, csr_mepc, $random(seed));
        csr_step(csr_rs, csr_mepc, $random(seed));
        csr_step(csr_rc, csr_mepc, $random(seed));
        csr_step(csr_rw, csr_unimpl, 32'hffff_ffff);

        // store, load back, patch one byte lane and load again
        repeat (n_rand) begin
            addr   = $random(seed) & 32'h0000_03fc;
            data   = $random(seed);
            bval   = 8'($random(seed));
            lane   = 2'($random(seed));
            merged = data;
            merged[{lane, 3'b000} +: 8] = bval;
            store(mem_sw, addr, data);
            load(mem_lw, 5'($random(seed)), addr, data);
            store(mem_sb, addr | 32'(lane), 32'(bval));
            load(mem_lbu, 5'($random(seed)), addr | 32'(lane), 32'(bval));
            load(mem_lw, 5'($random(seed)), addr, merged);
            rd = 5'($random(seed));
            alu(1'(rd[0] | rd[1]), rd, $random(seed));
        end

        send(1'b0, '0, '0, mem_none, '0, csr_none, '0, '0, 1'b1, '0);
        idle(1);
        while (!halt_o) begin
            @(posedge clock);
        end
        // an item offered while halted must not be taken
        ex_valid_i   <= 1'b1;
        wd_i         <= 1'b1;
        wreg_i       <= 5'd7;
        alu_result_i <= 32'h5555_aaaa;
        ebreak_i     <= 1'b0;
        repeat (4) @(posedge clock);
        ex_valid_i <= 1'b0;

        check_csr(csr_minstret, 32'(issued));
        check_csr(csr_unimpl, '0);
        for (int r = 0; r < 32; r++) begin
            rs1_i <= 5'(r);
            @(posedge clock);
            check($sformatf("rs1_data_o[x%0d]", r), rs1_data_o, model_regs[r]);
        end

        if (dut_i.asserts_i.fail_count == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("ERRORS FOUND");
            $fatal(1, "assertion failures were reported by backend_asserts");
        end
    end

endmodule

// ==== backend.f ====
design/core_pkg.sv
design/data_mem.sv
design/lsu.sv
design/wbu.sv
design/reg_file.sv
design/csr_file.sv
design/backend.sv
tests/backend_asserts.sv
tests/backend_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run backend_tb with Verilator, result decided from sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module backend_tb -f backend.f -o backend_sim
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

# keep running past a failed assertion so the testbench can end the run
./obj_dir/backend_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
